// File: hw/video_macros.svh
`ifndef VIDEO_MACROS_SVH
`define VIDEO_MACROS_SVH

// line timing, in cend periods (7 MHz pixel clock)
`define HBLNK_BEG 9'd0
`define HSYNC_BEG 9'd10   // sync starts 10 periods into blank
`define HSYNC_END 9'd43   // 33 periods of sync
`define HBLNK_END 9'd84
`define HPIX_BEG  9'd148  // 64 periods after line_start
`define HPIX_END  9'd404
`define HINT_BEG  9'd3    // horizontal interrupt position
`define HPERIOD   9'd448

// frame timing, in lines
`define VBLNK_BEG 9'd0
`define VSYNC_BEG 9'd8
`define VSYNC_END 9'd12   // 4 lines of frame sync
`define VBLNK_END 9'd32
`define VPIX_BEG  9'd80
`define VPIX_END  9'd272  // 192 visible lines
`define VINT_LINE 9'd0
`define VPERIOD   9'd320

`define INT_LEN   6'd32   // irq length in cend periods
`define CLK_DIV   3'd4    // clk cycles per cend

`endif

// File: hw/video_pkg.sv
package video_pkg;

	// position within a line, one step per cend
	typedef logic [8:0] hcount_t;

	// line number within a frame
	typedef logic [8:0] vcount_t;

	// colour index: bit 3 intensity, bits 2..0 rgb
	typedef logic [3:0] pixel_t;

	// interrupt request FSM
	typedef enum logic
	{
		int_idle,   // waiting for the interrupt position
		int_active  // irq asserted, length counter running
	} int_state_t;

endpackage

// File: hw/strobe_gen.sv
`timescale 1ns/100ps
`include "video_macros.svh"

module strobe_gen
(
	input  logic clk,
	input  logic rst,
	input  logic init,      // async to the pixel phase, any clk
	output logic cend,      // pixel strobe, one clk in CLK_DIV
	output logic pre_cend,  // clk just before cend
	output logic init_cend  // init aligned onto a cend
);

	logic [1:0] phase;    // position within the pixel period
	logic       init_pend; // init seen, waiting for the next cend

	// free-running divider, wraps every CLK_DIV clocks
	always_ff @(posedge clk)
	begin
		if (rst)
			phase <= 2'd0;
		else
			phase <= phase + 2'd1;
	end

	assign pre_cend = (phase == 2'(`CLK_DIV - 3'd2));
	assign cend     = (phase == 2'(`CLK_DIV - 3'd1)); // 4th clk after reset

	// a new request wins over release, so it is never lost
	always_ff @(posedge clk)
	begin
		if (rst)
			init_pend <= 1'b0;
		else if (init)
			init_pend <= 1'b1;
		else if (cend)
			init_pend <= 1'b0; // released this cycle
	end

	assign init_cend = cend && init_pend;

endmodule

// File: hw/hsync_gen.sv
`timescale 1ns/100ps
`include "video_macros.svh"

// horizontal raster timing over one 448-period line
//
// hcount: 0 ..10 ......... 43 ........ 84 ... 148 ..... 404 ... 447
// hblank: 1111111111111111111111111111110000000000000000000000000000
// hsync : 0000011111111111111111000000000000000000000000000000000000
// hpix  : 0000000000000000000000000000000000001111111111100000000000
module hsync_gen
(
	input  logic clk,
	input  logic rst,
	input  logic cend,
	input  logic pre_cend,
	input  logic init_cend,   // re-phases the line to position 0
	output logic hblank,
	output logic hsync,
	output logic hpix,        // horizontal pixel window
	output logic line_start,  // pulse one period before the visible line
	output logic hsync_start, // pulse one period before hsync rises
	output logic hint_start   // pulse at the interrupt position
);

	video_pkg::hcount_t hcount;

	// line position, steps once per pixel period
	always_ff @(posedge clk)
	begin
		if (rst)
			hcount <= '0;
		else if (cend)
		begin
			if (init_cend || hcount == (`HPERIOD - 9'd1))
				hcount <= '0;
			else
				hcount <= hcount + 9'd1;
		end
	end

	// levels move one clk after the matching cend
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			hblank <= 1'b0;
			hsync  <= 1'b0;
			hpix   <= 1'b0;
		end
		else if (cend)
		begin
			if (hcount == `HBLNK_BEG)
				hblank <= 1'b1;
			else if (hcount == `HBLNK_END)
				hblank <= 1'b0;

			if (hcount == `HSYNC_BEG)
				hsync <= 1'b1;
			else if (hcount == `HSYNC_END)
				hsync <= 1'b0;

			if (hcount == `HPIX_BEG)
				hpix <= 1'b1;
			else if (hcount == `HPIX_END)
				hpix <= 1'b0;
		end
	end

	// strobes sampled on pre_cend, so they land on the following cend
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			line_start  <= 1'b0;
			hsync_start <= 1'b0;
			hint_start  <= 1'b0;
		end
		else
		begin
			line_start  <= pre_cend && (hcount == `HBLNK_END);
			hsync_start <= pre_cend && (hcount == `HSYNC_BEG);
			hint_start  <= pre_cend && (hcount == `HINT_BEG);
		end
	end

endmodule

// File: hw/vsync_gen.sv
`timescale 1ns/100ps
`include "video_macros.svh"

// vertical raster timing, 320 lines per frame
module vsync_gen
(
	input  logic clk,
	input  logic rst,
	input  logic hsync_start, // one pulse per line
	output logic vblank,
	output logic vsync,
	output logic vpix,        // vertical pixel window
	output logic int_line     // current line carries the interrupt
);

	video_pkg::vcount_t vcount;

	// line number, wraps at the end of the frame
	always_ff @(posedge clk)
	begin
		if (rst)
			vcount <= '0;
		else if (hsync_start)
		begin
			if (vcount == (`VPERIOD - 9'd1))
				vcount <= '0;
			else
				vcount <= vcount + 9'd1;
		end
	end

	// frame levels, all moved at the start of horizontal sync
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			vblank <= 1'b0;
			vsync  <= 1'b0;
			vpix   <= 1'b0;
		end
		else if (hsync_start)
		begin
			if (vcount == `VBLNK_BEG)
				vblank <= 1'b1;
			else if (vcount == `VBLNK_END)
				vblank <= 1'b0;

			if (vcount == `VSYNC_BEG)
				vsync <= 1'b1;
			else if (vcount == `VSYNC_END)
				vsync <= 1'b0;

			if (vcount == `VPIX_BEG)
				vpix <= 1'b1;
			else if (vcount == `VPIX_END)
				vpix <= 1'b0;
		end
	end

	assign int_line = (vcount == `VINT_LINE); // whole line, from the counter

endmodule

// File: hw/int_gen.sv
`timescale 1ns/100ps
`include "video_macros.svh"

// frame interrupt of fixed length
module int_gen
(
	input  logic clk,
	input  logic rst,
	input  logic cend,
	input  logic hint_start, // horizontal interrupt position
	input  logic int_line,   // interrupt line of the frame
	output logic irq
);

	video_pkg::int_state_t state;
	logic [5:0]            int_cnt; // cend periods left

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state   <= video_pkg::int_idle;
			int_cnt <= '0;
		end
		else
		begin
			case (state)
				video_pkg::int_idle:
				begin
					if (hint_start && int_line)
					begin
						state   <= video_pkg::int_active;
						int_cnt <= `INT_LEN; // hint_start is itself a cend
					end
				end
				video_pkg::int_active:
				begin
					if (cend)
					begin
						int_cnt <= int_cnt - 6'd1;
						if (int_cnt == 6'd1) // last period done
							state <= video_pkg::int_idle;
					end
				end
				default: state <= video_pkg::int_idle;
			endcase
		end
	end

	assign irq = (state == video_pkg::int_active); // one clk after hint_start

endmodule

// File: hw/video_out.sv
`timescale 1ns/100ps

// final colour mux and composite sync, one register stage
module video_out
(
	input  logic              clk,
	input  logic              rst,
	input  logic              cend,
	input  logic              hblank,
	input  logic              vblank,
	input  logic              hsync,
	input  logic              vsync,
	input  logic              hpix,
	input  logic              vpix,
	input  video_pkg::pixel_t border,   // border colour index
	input  video_pkg::pixel_t pixel_in, // already a colour index
	output video_pkg::pixel_t rgb,
	output logic              csync,
	output logic              pix_gate  // pixel window, as seen at the output
);

	logic in_window; // both pixel windows open

	assign in_window = hpix && vpix;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			rgb      <= '0;
			csync    <= 1'b0;
			pix_gate <= 1'b0;
		end
		else if (cend)
		begin
			// blank first: no colour may leak into retrace
			if (hblank || vblank)
				rgb <= '0;
			else if (in_window)
				rgb <= pixel_in;
			else
				rgb <= border;

			csync    <= hsync || vsync; // simple or of both syncs
			pix_gate <= in_window;
		end
	end

endmodule

// File: hw/video_sync_top.sv
`timescale 1ns/100ps

module video_sync_top
(
	input  logic              clk,
	input  logic              rst,
	input  logic              init,       // re-phase request for the line
	input  video_pkg::pixel_t border,
	input  video_pkg::pixel_t pixel_in,
	output video_pkg::pixel_t rgb,
	output logic              csync,
	output logic              hsync,
	output logic              vsync,
	output logic              irq,
	output logic              pix_gate,
	output logic              line_start
);

	logic cend;
	logic pre_cend;
	logic init_cend;
	logic hblank;
	logic hpix;
	logic hsync_start; // steps the frame counter
	logic hint_start;
	logic vblank;
	logic vpix;
	logic int_line;

	strobe_gen strobe_gen_inst
	(
		.clk       (clk),
		.rst       (rst),
		.init      (init),
		.cend      (cend),
		.pre_cend  (pre_cend),
		.init_cend (init_cend)
	);

	hsync_gen hsync_gen_inst
	(
		.clk         (clk),
		.rst         (rst),
		.cend        (cend),
		.pre_cend    (pre_cend),
		.init_cend   (init_cend),
		.hblank      (hblank),
		.hsync       (hsync),
		.hpix        (hpix),
		.line_start  (line_start),
		.hsync_start (hsync_start),
		.hint_start  (hint_start)
	);

	vsync_gen vsync_gen_inst
	(
		.clk         (clk),
		.rst         (rst),
		.hsync_start (hsync_start),
		.vblank      (vblank),
		.vsync       (vsync),
		.vpix        (vpix),
		.int_line    (int_line)
	);

	int_gen int_gen_inst
	(
		.clk        (clk),
		.rst        (rst),
		.cend       (cend),
		.hint_start (hint_start),
		.int_line   (int_line),
		.irq        (irq)
	);

	video_out video_out_inst
	(
		.clk      (clk),
		.rst      (rst),
		.cend     (cend),
		.hblank   (hblank),
		.vblank   (vblank),
		.hsync    (hsync),
		.vsync    (vsync),
		.hpix     (hpix),
		.vpix     (vpix),
		.border   (border),
		.pixel_in (pixel_in),
		.rgb      (rgb),
		.csync    (csync),
		.pix_gate (pix_gate)
	);

endmodule

// File: test/video_sync_tb.sv
`timescale 1ns/100ps
`include "video_macros.svh"

module video_sync_tb;

	localparam int CYCLE_LIMIT = 1_200_000; // two frames of 573440 clk plus margin
	localparam int LS_DELAY = int'(`HBLNK_END - `HSYNC_BEG); // hsync rise to line_start

	logic              clk;
	logic              rst = 1'b1;
	logic              init = 1'b0;
	video_pkg::pixel_t border = '0;
	video_pkg::pixel_t pixel_in = '0;
	video_pkg::pixel_t rgb;
	logic              csync, hsync, vsync, irq, pix_gate, line_start;

	logic [1:0]  ph;                            // model cend phase with cend at 3
	logic [8:0]  h, v;                          // model line position and line number
	logic        pend;                          // init waiting for its cend
	logic        hbl, hsy, hpx, vbl, vsy, vpx;  // model levels
	logic        csync_exp, pg_exp;
	logic [3:0]  rgb_exp;
	logic        hsync_d, vsync_d, irq_d, ls_d; // previous samples for edge detection
	int          ncend, nline, ls_count, irq_count;
	int          hs_rise, vs_rise, irq_rise, irq_line, init_n;
	int          cyc = 0;
	int          fails [1:6];
	int          hits [1:6];                    // proof that each check was reached
	logic [31:0] lfsr = 32'h387b;
	logic [7:0]  bits;
	logic        init_sent = 1'b0;
	string       test_name [1:6] = '{"hsync and csync", "line_start", "vsync",
		"frame irq", "rgb and pix_gate", "init re-phase"};

	video_sync_top video_sync_top_inst
	(
		.clk        (clk),
		.rst        (rst),
		.init       (init),
		.border     (border),
		.pixel_in   (pixel_in),
		.rgb        (rgb),
		.csync      (csync),
		.hsync      (hsync),
		.vsync      (vsync),
		.irq        (irq),
		.pix_gate   (pix_gate),
		.line_start (line_start)
	);

	// galois form with taps for x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic value_err(input int t, input string sig, input int exp_val, input int act_val);
		$display("ERR %0t %s expected %0d actual %0d", $time, sig, exp_val, act_val);
		fails[t]++;
	endtask

	task automatic event_err(input int t, input string what);
		$display("test %0d at %0t: %s", t, $time, what);
		fails[t]++;
	endtask

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk; // 125 MHz stand-in for the 28 MHz clock
	end

	always @(posedge clk)
	begin
		cyc <= cyc + 1;
		rst <= (cyc < 7); // high for the first 8 edges
		init <= 1'b0;
		if (!rst && ph == 2'd3) // new colours on every cend
		begin
			for (int i = 0; i < 8; i++)
			begin
				bits[i] = lfsr[0];
				lfsr = lfsr_next(lfsr);
			end
			border   <= bits[3:0];
			pixel_in <= bits[7:4];
		end
		if (!init_sent && nline == 3 && h == 9'd200 && ph == 2'd0) // mid-line and after line_start
		begin
			init      <= 1'b1;
			init_sent <= 1'b1;
		end
	end

	always @(posedge clk)
	begin
		if (rst)
		begin
			ph <= 2'd0;
			h  <= '0;
			v  <= '0;
			{pend, hbl, hsy, hpx, vbl, vsy, vpx, csync_exp, pg_exp} <= '0;
			rgb_exp <= '0;
			{hsync_d, vsync_d, irq_d, ls_d} <= '0;
			{ncend, nline, ls_count, irq_count} <= '0;
			{hs_rise, vs_rise, irq_rise, irq_line, init_n} <= '1; // all -1, no event yet
		end
		else
		begin
			assert (hsync == hsy) else value_err(1, "hsync", int'(hsy), int'(hsync));
			assert (csync == csync_exp) else value_err(1, "csync", int'(csync_exp), int'(csync));
			assert (vsync == vsy) else value_err(3, "vsync", int'(vsy), int'(vsync));
			assert (rgb == rgb_exp) else value_err(5, "rgb", int'(rgb_exp), int'(rgb));
			assert (pix_gate == pg_exp) else value_err(5, "pix_gate", int'(pg_exp), int'(pix_gate));
			if (pg_exp)
				hits[5]++;

			// ncend here is the index of the cend that caused an edge
			if (hsync && !hsync_d)
			begin
				if (init_n >= 0)
				begin
					assert (ncend - init_n == int'(`HSYNC_BEG) + 1)
					else value_err(6, "hsync after init", int'(`HSYNC_BEG) + 1, ncend - init_n);
					hits[6]++;
					init_n <= -1; // re-phased line has no full period
				end
				else if (hs_rise >= 0)
				begin
					assert (ncend - hs_rise == int'(`HPERIOD))
					else value_err(1, "hsync period", int'(`HPERIOD), ncend - hs_rise);
				end
				if (hs_rise >= 0)
				begin
					assert (ls_count == 1) else event_err(2, "line_start count in a line is not one");
				end
				hs_rise  <= ncend;
				ls_count <= 0;
			end
			if (!hsync && hsync_d)
			begin
				assert (ncend - hs_rise == int'(`HSYNC_END - `HSYNC_BEG))
				else value_err(1, "hsync width", int'(`HSYNC_END - `HSYNC_BEG), ncend - hs_rise);
				hits[1]++;
			end

			if (line_start)
			begin
				assert (ph == 2'd3) else event_err(2, "line_start does not coincide with a cend");
				assert (!ls_d) else event_err(2, "line_start longer than one clk");
				assert (ncend + 1 - hs_rise == LS_DELAY)
				else value_err(2, "line_start delay", LS_DELAY, ncend + 1 - hs_rise);
				ls_count <= ls_count + 1;
				hits[2]++;
			end

			if (vsync && !vsync_d)
			begin
				if (vs_rise >= 0)
				begin
					assert (nline - vs_rise == int'(`VPERIOD))
					else value_err(3, "vsync period", int'(`VPERIOD), nline - vs_rise);
				end
				vs_rise <= nline;
			end
			if (!vsync && vsync_d)
			begin
				assert (nline - vs_rise == int'(`VSYNC_END - `VSYNC_BEG))
				else value_err(3, "vsync width", int'(`VSYNC_END - `VSYNC_BEG), nline - vs_rise);
				hits[3]++;
			end

			if (irq && !irq_d)
			begin
				assert (v == `VINT_LINE) else value_err(4, "irq line", int'(`VINT_LINE), int'(v));
				if (irq_line >= 0)
				begin
					assert (nline - irq_line == int'(`VPERIOD))
					else value_err(4, "irq period", int'(`VPERIOD), nline - irq_line);
				end
				irq_rise  <= ncend;
				irq_line  <= nline;
				irq_count <= irq_count + 1;
			end
			if (!irq && irq_d)
			begin
				assert (ncend - irq_rise == int'(`INT_LEN))
				else value_err(4, "irq length", int'(`INT_LEN), ncend - irq_rise);
				hits[4]++;
			end
			{hsync_d, vsync_d, irq_d, ls_d} <= {hsync, vsync, irq, line_start};

			// reference raster stepped on its own cend
			ph <= ph + 2'd1;
			if (init)
				pend <= 1'b1;
			else if (ph == 2'd3)
				pend <= 1'b0;
			if (ph == 2'd3)
			begin
				ncend <= ncend + 1;
				if (pend)
					init_n <= ncend + 1; // cend carrying init_cend
				h <= (pend || h == `HPERIOD - 9'd1) ? '0 : h + 9'd1;
				if (h == `HBLNK_BEG)
					hbl <= 1'b1;
				else if (h == `HBLNK_END)
					hbl <= 1'b0;
				if (h == `HSYNC_BEG)
					hsy <= 1'b1;
				else if (h == `HSYNC_END)
					hsy <= 1'b0;
				if (h == `HPIX_BEG)
					hpx <= 1'b1;
				else if (h == `HPIX_END)
					hpx <= 1'b0;
				csync_exp <= hsy || vsy;
				pg_exp    <= hpx && vpx;
				rgb_exp   <= (hbl || vbl) ? 4'd0 : ((hpx && vpx) ? pixel_in : border);
				if (h == `HSYNC_BEG) // new frame line at the sync start
				begin
					nline <= nline + 1;
					v <= (v == `VPERIOD - 9'd1) ? '0 : v + 9'd1;
					if (v == `VBLNK_BEG)
						vbl <= 1'b1;
					else if (v == `VBLNK_END)
						vbl <= 1'b0;
					if (v == `VSYNC_BEG)
						vsy <= 1'b1;
					else if (v == `VSYNC_END)
						vsy <= 1'b0;
					if (v == `VPIX_BEG)
						vpx <= 1'b1;
					else if (v == `VPIX_END)
						vpx <= 1'b0;
				end
			end
		end
	end

	// three irq rises span two full frames
	initial
	begin
		int passed;
		int errors;
		logic ok;
		passed = 0;
		errors = 0;
		while (irq_count < 3 && cyc < CYCLE_LIMIT)
			@(posedge clk);
		if (cyc >= CYCLE_LIMIT)
			$display("timeout: frame interrupts stopped before the end of two frames");
		for (int t = 1; t <= 6; t++)
		begin
			ok = (hits[t] > 0) && (fails[t] == 0);
			$display("test %0d %s: %s, %0d events, %0d errors", t, test_name[t],
				ok ? "ok" : "FAIL", hits[t], fails[t]);
			passed += ok ? 1 : 0;
			errors += fails[t];
		end
		$display("%0d of 6 checks ok, %0d errors, %0d cycles", passed, errors, cyc);
		if (passed == 6 && cyc < CYCLE_LIMIT)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

// File: compile.f
+incdir+hw
hw/video_pkg.sv
hw/strobe_gen.sv
hw/hsync_gen.sv
hw/vsync_gen.sv
hw/int_gen.sv
hw/video_out.sv
hw/video_sync_top.sv
test/video_sync_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module video_sync_tb -f compile.f -o video_sync_sim \
	&& ./obj_dir/video_sync_sim > sim.log 2>&1 \
	&& cat sim.log \
	&& ! grep -q "tests failed" sim.log \
	|| exit 1
